/* Bender.yml */
package:
  name: i3c_flow

sources:
  - rtl/hci_pkg.sv
  - rtl/i3c_bus_pkg.sv
  - rtl/cmd_decoder.sv
  - rtl/flow_sequencer.sv
  - rtl/tx_byte_feeder.sv
  - rtl/rx_word_packer.sv
  - rtl/i3c_flow_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_i3c_flow.sv

/* dv/i3c_flow_model.svh */
// Reference model of one command giving data length, bus items, RX words and response
`ifndef I3C_FLOW_MODEL_SVH
`define I3C_FLOW_MODEL_SVH

// Immediate length is dtt up to 4 and regular length sits in the upper data half
function automatic logic [15:0] expected_length(input hci_pkg::cmd_desc_t d);
  logic [15:0] len;
  len = 16'd0;
  if (d.attr == hci_pkg::ImmediateDataTransfer) begin
    len = (d.dtt <= 3'd4) ? 16'(d.dtt) : 16'd0;
  end else if (d.attr == hci_pkg::RegularTransfer) begin
    len = d.data[31:16];
  end
  return len;
endfunction

function automatic i3c_bus_pkg::bus_req_t make_bus_item(input i3c_bus_pkg::bus_op_e     op,
                                                        input i3c_bus_pkg::start_stop_e cond,
                                                        input logic [7:0]             data);
  i3c_bus_pkg::bus_req_t item;
  item.op        = op;
  item.cond      = cond;
  item.data_byte = data;
  return item;
endfunction

// Fills the expected queues from tx_src and rx_src without popping them
task automatic build_expected(input hci_pkg::cmd_desc_t d, input hci_pkg::dat_entry_t ent);
  logic                      is_imm;
  logic [15:0]               len;
  logic [31:0]               word;
  logic [7:0]                data;
  int                        b;
  i3c_bus_pkg::start_stop_e  cond;
  hci_pkg::resp_desc_t       resp;
  is_imm = d.attr == hci_pkg::ImmediateDataTransfer;
  len    = expected_length(d);
  // Broadcast address takes Sr while the bus is still held from before
  cond = owned_m ? i3c_bus_pkg::RepeatedStart : i3c_bus_pkg::Start;
  exp_bus.push_back(make_bus_item(i3c_bus_pkg::OpAddr, cond, {i3c_bus_pkg::RsvdAddr, 1'b0}));
  owned_m = 1'b1;
  if (d.cp) begin
    exp_bus.push_back(make_bus_item(i3c_bus_pkg::OpData, i3c_bus_pkg::None, d.ccc));
  end
  // Private transfers and direct CCCs address the target
  if (!d.cp || d.ccc[7]) begin
    exp_bus.push_back(make_bus_item(i3c_bus_pkg::OpAddr, i3c_bus_pkg::RepeatedStart,
                                    {ent.dynamic_addr[6:0], d.rnw}));
  end
  if (len != 16'd0 && d.rnw) begin
    // Low byte first with the tail word zero padded
    word = '0;
    for (int i = 0; i < int'(len); i++) begin
      b = i % 4;
      word[b*8 +: 8] = rx_src[i];
      if (b == 3 || i == int'(len) - 1) begin
        exp_rx.push_back(word);
        word = '0;
      end
    end
  end else if (len != 16'd0) begin
    for (int i = 0; i < int'(len); i++) begin
      b    = i % 4;
      data = is_imm ? d.data[b*8 +: 8] : tx_src[i/4][b*8 +: 8];
      cond = (i == int'(len) - 1 && d.toc) ? i3c_bus_pkg::Stop : i3c_bus_pkg::None;
      exp_bus.push_back(make_bus_item(i3c_bus_pkg::OpData, cond, data));
    end
  end
  // Reads and empty transfers end with a STOP of its own
  if (d.toc && (len == 16'd0 || d.rnw)) begin
    exp_bus.push_back(make_bus_item(i3c_bus_pkg::OpStop, i3c_bus_pkg::Stop, 8'h00));
  end
  if (d.toc) begin
    owned_m = 1'b0;
  end
  if (!is_imm || d.wroc) begin
    resp             = '0;
    resp.err_status  = hci_pkg::Success;
    resp.tid         = d.tid;
    resp.data_length = d.rnw ? len : 16'd0;
    exp_resp.push_back(resp);
  end
endtask

`endif

/* dv/tb_i3c_flow.sv */
// Testbench for the command-flow engine with random commands, queue and bus
// responders under back-pressure, model-based checks and watchdog
`default_nettype none
`timescale 1ns/100ps

module tb_i3c_flow;

  localparam int NumCmds      = 40;
  localparam int CyclesPerCmd = 300;

  logic                              clk_i           = 1'b0;
  logic                              rst_ni          = 1'b0;
  logic                              en_i            = 1'b0;
  logic                              cmd_valid_i     = 1'b0;
  hci_pkg::cmd_desc_t                cmd_data_i      = '0;
  logic                              cmd_ready_o;
  logic                              dat_req_o;
  logic [hci_pkg::DatIndexWidth-1:0] dat_index_o;
  hci_pkg::dat_entry_t               dat_rdata_i     = '0;
  logic                              tx_valid_i      = 1'b0;
  logic [hci_pkg::QueueWidth-1:0]    tx_data_i       = '0;
  logic                              tx_ready_o;
  logic                              rx_q_valid_o;
  logic [hci_pkg::QueueWidth-1:0]    rx_q_data_o;
  logic                              rx_q_ready_i    = 1'b0;
  logic                              resp_valid_o;
  hci_pkg::resp_desc_t               resp_data_o;
  logic                              resp_ready_i    = 1'b0;
  logic                              bus_req_valid_o;
  i3c_bus_pkg::bus_req_t             bus_req_o;
  logic                              bus_req_ready_i = 1'b0;
  logic                              bus_rx_valid_i  = 1'b0;
  logic [7:0]                        bus_rx_byte_i   = '0;
  logic                              bus_rx_ready_o;

  // Pre-generated stimulus
  hci_pkg::cmd_desc_t  desc_arr [NumCmds];
  logic [31:0]         tx_pool  [NumCmds][4];
  logic [7:0]          rx_pool  [NumCmds][16];
  hci_pkg::dat_entry_t dat_mem  [32];

  // Payload still to be handed to the DUT
  logic [31:0] tx_src [$];
  logic [7:0]  rx_src [$];

  // Expected results from the model
  i3c_bus_pkg::bus_req_t exp_bus  [$];
  logic [31:0]           exp_rx   [$];
  hci_pkg::resp_desc_t   exp_resp [$];
  logic [hci_pkg::DatIndexWidth-1:0] exp_index = '0;
  logic                  owned_m = 1'b0;

  logic [31:0] lfsr_q       = 32'd92411;
  logic        cmd_accepted = 1'b0;
  logic        dat_due      = 1'b0;
  int          dat_req_cnt  = 0;
  int          err_bus      = 0;
  int          err_rx       = 0;
  int          err_resp     = 0;
  int          err_dat      = 0;
  int          err_other    = 0;

  `include "i3c_flow_model.svh"

  i3c_flow_top UUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .en_i            (en_i),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_data_i      (cmd_data_i),
    .cmd_ready_o     (cmd_ready_o),
    .dat_req_o       (dat_req_o),
    .dat_index_o     (dat_index_o),
    .dat_rdata_i     (dat_rdata_i),
    .tx_valid_i      (tx_valid_i),
    .tx_data_i       (tx_data_i),
    .tx_ready_o      (tx_ready_o),
    .rx_q_valid_o    (rx_q_valid_o),
    .rx_q_data_o     (rx_q_data_o),
    .rx_q_ready_i    (rx_q_ready_i),
    .resp_valid_o    (resp_valid_o),
    .resp_data_o     (resp_data_o),
    .resp_ready_i    (resp_ready_i),
    .bus_req_valid_o (bus_req_valid_o),
    .bus_req_o       (bus_req_o),
    .bus_req_ready_i (bus_req_ready_i),
    .bus_rx_valid_i  (bus_rx_valid_i),
    .bus_rx_byte_i   (bus_rx_byte_i),
    .bus_rx_ready_o  (bus_rx_ready_o)
  );

  always #4 clk_i = ~clk_i;

  // 32-bit Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic check_bus(input i3c_bus_pkg::bus_req_t got);
    i3c_bus_pkg::bus_req_t exp;
    if (exp_bus.size() == 0) begin
      $display("Bus request %h issued at %0t when none was due", got, $time);
      err_other++;
    end else begin
      exp = exp_bus.pop_front();
      if (got !== exp) begin
        $display("ERR %0t bus_req_o got %h exp %h", $time, got, exp);
        err_bus++;
      end
    end
  endtask

  task automatic check_rx_word(input logic [hci_pkg::QueueWidth-1:0] got);
    logic [hci_pkg::QueueWidth-1:0] exp;
    if (exp_rx.size() == 0) begin
      $display("RX queue word %h pushed at %0t when none was due", got, $time);
      err_other++;
    end else begin
      exp = exp_rx.pop_front();
      if (got !== exp) begin
        $display("ERR %0t rx_q_data_o got %h exp %h", $time, got, exp);
        err_rx++;
      end
    end
  endtask

  task automatic check_resp(input hci_pkg::resp_desc_t got);
    hci_pkg::resp_desc_t exp;
    if (exp_resp.size() == 0) begin
      $display("Response %h written at %0t when none was due", got, $time);
      err_other++;
    end else begin
      exp = exp_resp.pop_front();
      if (got !== exp) begin
        $display("ERR %0t resp_data_o got %h exp %h", $time, got, exp);
        err_resp++;
      end
    end
  endtask

  task automatic check_dat_index(input logic [hci_pkg::DatIndexWidth-1:0] got);
    if (got !== exp_index) begin
      $display("ERR %0t dat_index_o got %h exp %h", $time, got, exp_index);
      err_dat++;
    end
  endtask

  // Handshake monitor that also drains the payload queues
  always @(posedge clk_i) begin
    if (rst_ni) begin
      dat_due = dat_req_o;
      if (bus_req_valid_o && bus_req_ready_i) begin
        check_bus(bus_req_o);
      end
      if (rx_q_valid_o && rx_q_ready_i) begin
        check_rx_word(rx_q_data_o);
      end
      if (resp_valid_o && resp_ready_i) begin
        check_resp(resp_data_o);
      end
      if (dat_req_o) begin
        dat_req_cnt++;
        check_dat_index(dat_index_o);
      end
      if (tx_valid_i && tx_ready_o) begin
        void'(tx_src.pop_front());
      end
      if (bus_rx_valid_i && bus_rx_ready_o) begin
        void'(rx_src.pop_front());
      end
      if (cmd_valid_i && cmd_ready_o) begin
        cmd_accepted = 1'b1;
      end
    end
  end

  // Responders with random back-pressure and the same LFSR draws every cycle
  always @(negedge clk_i) begin
    logic tx_go;
    logic rx_go;
    bus_req_ready_i = rand_bits(2) != 0;
    rx_q_ready_i    = rand_bits(2) != 0;
    resp_ready_i    = rand_bits(2) != 0;
    tx_go           = rand_bits(1);
    rx_go           = rand_bits(1);
    tx_valid_i      = tx_go && (tx_src.size() > 0);
    tx_data_i       = (tx_src.size() > 0) ? tx_src[0] : '0;
    bus_rx_valid_i  = rx_go && (rx_src.size() > 0);
    bus_rx_byte_i   = (rx_src.size() > 0) ? rx_src[0] : '0;
    // DAT entry only in the cycle after the request, inverted otherwise
    dat_rdata_i     = dat_due ? dat_mem[dat_index_o] : ~dat_mem[dat_index_o];
  end

  // All commands and payloads drawn up front
  task automatic gen_stimulus();
    hci_pkg::cmd_desc_t d;
    for (int i = 0; i < 32; i++) begin
      dat_mem[i] = {rand_bits(32), rand_bits(32)};
    end
    for (int c = 0; c < NumCmds; c++) begin
      d           = '0;
      d.attr      = rand_bits(1) ? hci_pkg::ImmediateDataTransfer : hci_pkg::RegularTransfer;
      d.tid       = 4'(rand_bits(4));
      d.ccc       = 8'(rand_bits(8));
      d.cp        = rand_bits(1);
      d.dev_index = 5'(rand_bits(5));
      d.dtt       = 3'(rand_bits(3));
      d.rnw       = rand_bits(1);
      d.wroc      = rand_bits(1);
      d.toc       = rand_bits(1);
      d.data      = rand_bits(32);
      // Immediate transfers only write and regular lengths stay below 16
      if (d.attr == hci_pkg::ImmediateDataTransfer) begin
        d.rnw = 1'b0;
      end else begin
        d.data[31:16] = 16'(rand_bits(4));
      end
      desc_arr[c] = d;
      for (int w = 0; w < 4; w++) begin
        tx_pool[c][w] = rand_bits(32);
      end
      for (int b = 0; b < 16; b++) begin
        rx_pool[c][b] = 8'(rand_bits(8));
      end
    end
  endtask

  task automatic run_command(input int c);
    hci_pkg::cmd_desc_t d;
    logic [15:0]        len;
    d   = desc_arr[c];
    len = expected_length(d);
    if (d.rnw) begin
      for (int i = 0; i < int'(len); i++) begin
        rx_src.push_back(rx_pool[c][i]);
      end
    end else if (d.attr == hci_pkg::RegularTransfer) begin
      for (int i = 0; i < (int'(len) + 3) / 4; i++) begin
        tx_src.push_back(tx_pool[c][i]);
      end
    end
    exp_index = d.dev_index;
    build_expected(d, dat_mem[d.dev_index]);
    cmd_accepted = 1'b0;
    cmd_data_i   = d;
    cmd_valid_i  = 1'b1;
    do begin
      @(negedge clk_i);
    end while (!cmd_accepted);
    cmd_valid_i = 1'b0;
    // Done once every expected item has been seen
    while (exp_bus.size() != 0 || exp_rx.size() != 0 || exp_resp.size() != 0) begin
      @(negedge clk_i);
    end
    if (tx_src.size() != 0 || rx_src.size() != 0) begin
      $display("Command %0d left %0d TX words and %0d RX bytes unused",
               c, tx_src.size(), rx_src.size());
      err_other++;
    end
    if (dat_req_cnt != c + 1) begin
      $display("Command %0d saw %0d DAT lookups in total, expected %0d",
               c, dat_req_cnt, c + 1);
      err_other++;
    end
  endtask

  initial begin
    int total;
    gen_stimulus();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    en_i   = 1'b1;
    for (int c = 0; c < NumCmds; c++) begin
      run_command(c);
    end
    total = err_bus + err_rx + err_resp + err_dat + err_other;
    $display("Error counts: bus %0d, rx %0d, resp %0d, dat %0d, other %0d",
             err_bus, err_rx, err_resp, err_dat, err_other);
    if (total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog bound scales with the command count
  initial begin
    repeat (NumCmds * CyclesPerCmd) @(posedge clk_i);
    $display("Timeout: commands still outstanding after %0d cycles",
             NumCmds * CyclesPerCmd);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* i3c_flow.f */
+incdir+dv
rtl/hci_pkg.sv
rtl/i3c_bus_pkg.sv
rtl/cmd_decoder.sv
rtl/flow_sequencer.sv
rtl/tx_byte_feeder.sv
rtl/rx_word_packer.sv
rtl/i3c_flow_top.sv
dv/tb_i3c_flow.sv

/* rtl/cmd_decoder.sv */
// Command descriptor capture and decode into the command info struct
`default_nettype none
`timescale 1ns/100ps

module cmd_decoder (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               cmd_valid_i,
  input  logic               cmd_ready_i,
  input  hci_pkg::cmd_desc_t cmd_data_i,
  output hci_pkg::cmd_info_t cmd_info_o
);

  logic [hci_pkg::CmdWidth-1:0] desc_raw_q;
  hci_pkg::cmd_desc_t           desc;
  hci_pkg::cmd_attr_e           attr;

  // Hold the descriptor for the whole command
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      desc_raw_q <= '0;
    end else if (cmd_valid_i && cmd_ready_i) begin
      desc_raw_q <= cmd_data_i;
    end
  end

  assign desc = hci_pkg::cmd_desc_t'(desc_raw_q);
  assign attr = hci_pkg::cmd_attr_e'(desc.attr);

  always_comb begin
    cmd_info_o.is_imm    = attr == hci_pkg::ImmediateDataTransfer;
    cmd_info_o.is_ccc    = desc.cp;
    // Top bit of the CCC code marks a direct CCC
    cmd_info_o.is_direct = desc.cp && desc.ccc[7];
    cmd_info_o.is_read   = desc.rnw;
    cmd_info_o.toc       = desc.toc;
    cmd_info_o.wroc      = desc.wroc;
    cmd_info_o.tid       = desc.tid;
    cmd_info_o.dev_index = desc.dev_index;
    cmd_info_o.ccc       = desc.ccc;
    cmd_info_o.imm_bytes = desc.data;
    unique case (attr)
      // Codes above 4 carry a defining byte, which is not served
      hci_pkg::ImmediateDataTransfer: begin
        cmd_info_o.data_length = (desc.dtt <= 3'd4) ? 16'(desc.dtt) : 16'd0;
      end
      hci_pkg::RegularTransfer: begin
        cmd_info_o.data_length = desc.data[31:16];
      end
      default: begin
        cmd_info_o.data_length = 16'd0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/flow_sequencer.sv */
// Transfer FSM with byte counter, bus ownership, DAT lookup and response write
`default_nettype none
`timescale 1ns/100ps

module flow_sequencer (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     en_i,
  // Command handshake and decoded command
  input  logic                                     cmd_valid_i,
  output logic                                     cmd_ready_o,
  input  hci_pkg::cmd_info_t                       cmd_info_i,
  // DAT lookup
  output logic                                     dat_req_o,
  output logic [hci_pkg::DatIndexWidth-1:0]        dat_index_o,
  input  hci_pkg::dat_entry_t                      dat_rdata_i,
  // Bus controller
  output logic                                     bus_req_valid_o,
  output i3c_bus_pkg::bus_req_t                    bus_req_o,
  input  logic                                     bus_req_ready_i,
  input  logic                                     bus_rx_valid_i,
  output logic                                     bus_rx_ready_o,
  // TX byte feeder
  input  logic [7:0]                               tx_byte_i,
  output logic                                     tx_fetch_req_o,
  input  logic                                     tx_fetch_done_i,
  output logic [$clog2(hci_pkg::BytesPerWord)-1:0] byte_sel_o,
  // RX word packer
  output logic                                     rx_active_o,
  input  logic                                     rx_word_full_i,
  output logic                                     rx_flush_o,
  input  logic                                     rx_flush_done_i,
  // Response queue
  output logic                                     resp_valid_o,
  output hci_pkg::resp_desc_t                      resp_data_o,
  input  logic                                     resp_ready_i
);

  typedef enum logic [3:0] {
    Idle,
    WaitForCmd,
    FetchDat,
    BroadcastAddr,
    SendCcc,
    TargetAddr,
    FetchTxData,
    DataWrite,
    DataRead,
    PushRx,
    SendStop,
    WriteResp
  } state_e;

  state_e              state_q, state_d;
  state_e              data_state;
  state_e              done_state;
  logic [15:0]         cnt_q, cnt_d;
  logic                owned_q, owned_d;
  logic                dat_wait_q;
  hci_pkg::dat_entry_t dat_q;
  logic                last_byte;

  assign dat_index_o = cmd_info_i.dev_index;
  assign byte_sel_o  = cnt_q[$clog2(hci_pkg::BytesPerWord)-1:0];
  assign last_byte   = cnt_q == cmd_info_i.data_length - 16'd1;

  // Immediate commands skip the response unless wroc is set
  assign done_state = (cmd_info_i.is_imm && !cmd_info_i.wroc) ? Idle : WriteResp;

  // Entry into the data phase once the address bytes are out
  always_comb begin
    if (cmd_info_i.data_length == 16'd0) begin
      // Nothing to move but toc still releases the bus
      data_state = cmd_info_i.toc ? SendStop : done_state;
    end else if (cmd_info_i.is_read) begin
      data_state = DataRead;
    end else if (cmd_info_i.is_imm) begin
      data_state = DataWrite;
    end else begin
      data_state = FetchTxData;
    end
  end

  // Response carries the count of bytes read
  always_comb begin
    resp_data_o             = '0;
    resp_data_o.err_status  = hci_pkg::Success;
    resp_data_o.tid         = cmd_info_i.tid;
    resp_data_o.data_length = cmd_info_i.is_read ? cnt_q : 16'd0;
  end

  always_comb begin
    state_d             = state_q;
    cnt_d               = cnt_q;
    owned_d             = owned_q;
    cmd_ready_o         = 1'b0;
    dat_req_o           = 1'b0;
    bus_req_valid_o     = 1'b0;
    bus_req_o.op        = i3c_bus_pkg::OpData;
    bus_req_o.cond      = i3c_bus_pkg::None;
    bus_req_o.data_byte = tx_byte_i;
    bus_rx_ready_o      = 1'b0;
    tx_fetch_req_o      = 1'b0;
    rx_active_o         = 1'b0;
    rx_flush_o          = 1'b0;
    resp_valid_o        = 1'b0;
    unique case (state_q)
      Idle: begin
        if (en_i) begin
          state_d = WaitForCmd;
        end
      end
      WaitForCmd: begin
        cmd_ready_o = 1'b1;
        if (cmd_valid_i) begin
          cnt_d   = '0;
          state_d = FetchDat;
        end
      end
      // Request in the first cycle and capture of the entry in the second
      FetchDat: begin
        dat_req_o = !dat_wait_q;
        if (dat_wait_q) begin
          state_d = BroadcastAddr;
        end
      end
      // 7E/W with Start when the bus is free and Sr while it is still ours
      BroadcastAddr: begin
        bus_req_valid_o     = 1'b1;
        bus_req_o.op        = i3c_bus_pkg::OpAddr;
        bus_req_o.cond      = owned_q ? i3c_bus_pkg::RepeatedStart : i3c_bus_pkg::Start;
        bus_req_o.data_byte = {i3c_bus_pkg::RsvdAddr, 1'b0};
        if (bus_req_ready_i) begin
          owned_d = 1'b1;
          state_d = cmd_info_i.is_ccc ? SendCcc : TargetAddr;
        end
      end
      SendCcc: begin
        bus_req_valid_o     = 1'b1;
        bus_req_o.data_byte = cmd_info_i.ccc;
        if (bus_req_ready_i) begin
          state_d = cmd_info_i.is_direct ? TargetAddr : data_state;
        end
      end
      // Bit 7 of the DAT field is parity and not sent
      TargetAddr: begin
        bus_req_valid_o     = 1'b1;
        bus_req_o.op        = i3c_bus_pkg::OpAddr;
        bus_req_o.cond      = i3c_bus_pkg::RepeatedStart;
        bus_req_o.data_byte = {dat_q.dynamic_addr[6:0], cmd_info_i.is_read};
        if (bus_req_ready_i) begin
          state_d = data_state;
        end
      end
      FetchTxData: begin
        tx_fetch_req_o = 1'b1;
        if (tx_fetch_done_i) begin
          state_d = DataWrite;
        end
      end
      DataWrite: begin
        bus_req_valid_o = 1'b1;
        if (last_byte && cmd_info_i.toc) begin
          bus_req_o.cond = i3c_bus_pkg::Stop;
        end
        if (bus_req_ready_i) begin
          cnt_d = cnt_q + 16'd1;
          if (last_byte) begin
            owned_d = !cmd_info_i.toc;
            state_d = done_state;
          end else if (!cmd_info_i.is_imm && byte_sel_o == '1) begin
            // Word used up so the next one is fetched
            state_d = FetchTxData;
          end
        end
      end
      DataRead: begin
        bus_rx_ready_o = 1'b1;
        rx_active_o    = 1'b1;
        if (bus_rx_valid_i) begin
          cnt_d = cnt_q + 16'd1;
          if (last_byte || rx_word_full_i) begin
            state_d = PushRx;
          end
        end
      end
      // Bus reads stall while the word waits for the RX queue
      PushRx: begin
        rx_flush_o = 1'b1;
        if (rx_flush_done_i) begin
          if (cnt_q == cmd_info_i.data_length) begin
            state_d = cmd_info_i.toc ? SendStop : done_state;
          end else begin
            state_d = DataRead;
          end
        end
      end
      SendStop: begin
        bus_req_valid_o     = 1'b1;
        bus_req_o.op        = i3c_bus_pkg::OpStop;
        bus_req_o.cond      = i3c_bus_pkg::Stop;
        bus_req_o.data_byte = 8'h00;
        if (bus_req_ready_i) begin
          owned_d = 1'b0;
          state_d = done_state;
        end
      end
      WriteResp: begin
        resp_valid_o = 1'b1;
        if (resp_ready_i) begin
          state_d = Idle;
        end
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Idle;
      cnt_q      <= '0;
      owned_q    <= 1'b0;
      dat_wait_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      cnt_q      <= cnt_d;
      owned_q    <= owned_d;
      dat_wait_q <= dat_req_o;
    end
  end

  // DAT entry is valid the cycle after the request
  always_ff @(posedge clk_i) begin
    if (dat_wait_q) begin
      dat_q <= dat_rdata_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/hci_pkg.sv */
// Host controller interface types: command and response descriptors,
// DAT entry, decoded command info and queue widths
`default_nettype none

package hci_pkg;

  localparam int unsigned CmdWidth      = 64;
  localparam int unsigned QueueWidth    = 32;
  localparam int unsigned DatIndexWidth = 5;
  localparam int unsigned BytesPerWord  = 4;

  // Command attribute codes from the HCI command descriptor
  typedef enum logic [2:0] {
    RegularTransfer       = 3'd0,
    ImmediateDataTransfer = 3'd1,
    AddressAssignment     = 3'd2,
    ComboTransfer         = 3'd3,
    InternalControl       = 3'd7
  } cmd_attr_e;

  // Common layout of regular and immediate descriptors
  typedef struct packed {
    logic [31:0]              data;       // Imm bytes, or length in the upper half
    logic                     toc;
    logic                     wroc;
    logic                     rnw;
    logic [2:0]               rsvd_28_26;
    logic [2:0]               dtt;
    logic [1:0]               rsvd_22_21;
    logic [DatIndexWidth-1:0] dev_index;
    logic                     cp;
    logic [7:0]               ccc;
    logic [3:0]               tid;
    logic [2:0]               attr;
  } cmd_desc_t;

  typedef struct packed {
    logic                     is_imm;
    logic                     is_ccc;
    logic                     is_direct;
    logic                     is_read;
    logic                     toc;
    logic                     wroc;
    logic [3:0]               tid;
    logic [DatIndexWidth-1:0] dev_index;
    logic [7:0]               ccc;
    logic [15:0]              data_length;
    logic [31:0]              imm_bytes;
  } cmd_info_t;

  // Dynamic address sits in bits 23:16, bit 23 being its parity
  typedef struct packed {
    logic [39:0] rsvd_hi;
    logic [7:0]  dynamic_addr;
    logic [15:0] rsvd_lo;
  } dat_entry_t;

  typedef enum logic [3:0] {
    Success = 4'h0,
    Crc     = 4'h1,
    Parity  = 4'h2,
    Frame   = 4'h3,
    Nack    = 4'h5
  } resp_err_e;

  typedef struct packed {
    resp_err_e   err_status;
    logic [3:0]  tid;
    logic [7:0]  rsvd;
    logic [15:0] data_length;
  } resp_desc_t;

endpackage

`default_nettype wire

/* rtl/i3c_bus_pkg.sv */
// Bus-side request type, operation and start/stop enums
`default_nettype none

package i3c_bus_pkg;

  // Broadcast address sent ahead of every command
  localparam logic [6:0] RsvdAddr = 7'h7E;

  typedef enum logic [1:0] {
    OpAddr = 2'd0,  // Open-drain, expects ACK
    OpData = 2'd1,  // Push-pull with T-bit
    OpStop = 2'd2   // STOP condition only
  } bus_op_e;

  typedef enum logic [1:0] {
    None          = 2'd0,
    Start         = 2'd1,
    RepeatedStart = 2'd2,
    Stop          = 2'd3
  } start_stop_e;

  typedef struct packed {
    bus_op_e     op;
    start_stop_e cond;
    logic [7:0]  data_byte;
  } bus_req_t;

endpackage

`default_nettype wire

/* rtl/i3c_flow_top.sv */
// Command-flow engine top: decoder, sequencer, TX byte feeder, RX word packer
`default_nettype none
`timescale 1ns/100ps

module i3c_flow_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              en_i,
  // Command queue
  input  logic                              cmd_valid_i,
  input  hci_pkg::cmd_desc_t                cmd_data_i,
  output logic                              cmd_ready_o,
  // Device address table
  output logic                              dat_req_o,
  output logic [hci_pkg::DatIndexWidth-1:0] dat_index_o,
  input  hci_pkg::dat_entry_t               dat_rdata_i,
  // TX queue
  input  logic                              tx_valid_i,
  input  logic [hci_pkg::QueueWidth-1:0]    tx_data_i,
  output logic                              tx_ready_o,
  // RX queue
  output logic                              rx_q_valid_o,
  output logic [hci_pkg::QueueWidth-1:0]    rx_q_data_o,
  input  logic                              rx_q_ready_i,
  // Response queue
  output logic                              resp_valid_o,
  output hci_pkg::resp_desc_t               resp_data_o,
  input  logic                              resp_ready_i,
  // Bus controller requests and received bytes
  output logic                              bus_req_valid_o,
  output i3c_bus_pkg::bus_req_t             bus_req_o,
  input  logic                              bus_req_ready_i,
  input  logic                              bus_rx_valid_i,
  input  logic [7:0]                        bus_rx_byte_i,
  output logic                              bus_rx_ready_o
);

  hci_pkg::cmd_info_t                        cmd_info;
  logic                                      tx_fetch_req;
  logic                                      tx_fetch_done;
  logic [$clog2(hci_pkg::BytesPerWord)-1:0]  byte_sel;
  logic [7:0]                                tx_byte;
  logic                                      rx_active;
  logic                                      rx_word_full;
  logic                                      rx_flush;
  logic                                      rx_flush_done;

  cmd_decoder u_cmd_decoder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_i (cmd_ready_o),
    .cmd_data_i  (cmd_data_i),
    .cmd_info_o  (cmd_info)
  );

  flow_sequencer u_flow_sequencer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .en_i            (en_i),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_ready_o     (cmd_ready_o),
    .cmd_info_i      (cmd_info),
    .dat_req_o       (dat_req_o),
    .dat_index_o     (dat_index_o),
    .dat_rdata_i     (dat_rdata_i),
    .bus_req_valid_o (bus_req_valid_o),
    .bus_req_o       (bus_req_o),
    .bus_req_ready_i (bus_req_ready_i),
    .bus_rx_valid_i  (bus_rx_valid_i),
    .bus_rx_ready_o  (bus_rx_ready_o),
    .tx_byte_i       (tx_byte),
    .tx_fetch_req_o  (tx_fetch_req),
    .tx_fetch_done_i (tx_fetch_done),
    .byte_sel_o      (byte_sel),
    .rx_active_o     (rx_active),
    .rx_word_full_i  (rx_word_full),
    .rx_flush_o      (rx_flush),
    .rx_flush_done_i (rx_flush_done),
    .resp_valid_o    (resp_valid_o),
    .resp_data_o     (resp_data_o),
    .resp_ready_i    (resp_ready_i)
  );

  tx_byte_feeder u_tx_byte_feeder (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_info_i   (cmd_info),
    .fetch_req_i  (tx_fetch_req),
    .fetch_done_o (tx_fetch_done),
    .byte_sel_i   (byte_sel),
    .data_byte_o  (tx_byte),
    .tx_valid_i   (tx_valid_i),
    .tx_data_i    (tx_data_i),
    .tx_ready_o   (tx_ready_o)
  );

  rx_word_packer u_rx_word_packer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .active_i       (rx_active),
    .bus_rx_valid_i (bus_rx_valid_i),
    .bus_rx_byte_i  (bus_rx_byte_i),
    .word_full_o    (rx_word_full),
    .flush_i        (rx_flush),
    .flush_done_o   (rx_flush_done),
    .rx_q_valid_o   (rx_q_valid_o),
    .rx_q_data_o    (rx_q_data_o),
    .rx_q_ready_i   (rx_q_ready_i)
  );

endmodule

`default_nettype wire

/* rtl/rx_word_packer.sv */
// Received byte packing into 32-bit words and RX queue push
`default_nettype none
`timescale 1ns/100ps

module rx_word_packer (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           active_i,
  input  logic                           bus_rx_valid_i,
  input  logic [7:0]                     bus_rx_byte_i,
  output logic                           word_full_o,
  input  logic                           flush_i,
  output logic                           flush_done_o,
  output logic                           rx_q_valid_o,
  output logic [hci_pkg::QueueWidth-1:0] rx_q_data_o,
  input  logic                           rx_q_ready_i
);

  logic [$clog2(hci_pkg::BytesPerWord)-1:0] pos_q;
  logic [hci_pkg::QueueWidth-1:0]           word_q;
  logic [hci_pkg::QueueWidth-1:0]           keep_mask;
  logic                                     take;

  assign take        = active_i && bus_rx_valid_i;
  assign word_full_o = take && (pos_q == '1);

  // Byte position and end of flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pos_q <= '0;
    end else if (flush_done_o) begin
      pos_q <= '0;
    end else if (take) begin
      pos_q <= pos_q + 1'b1;
    end
  end

  // Low byte first
  always_ff @(posedge clk_i) begin
    if (take) begin
      word_q[{pos_q, 3'b000} +: 8] <= bus_rx_byte_i;
    end
  end

  // Position zero means the word wrapped full
  always_comb begin
    unique case (pos_q)
      2'd1:    keep_mask = 32'h0000_00FF;
      2'd2:    keep_mask = 32'h0000_FFFF;
      2'd3:    keep_mask = 32'h00FF_FFFF;
      default: keep_mask = 32'hFFFF_FFFF;
    endcase
  end

  // Push holds until the RX queue takes it
  assign rx_q_valid_o = flush_i;
  assign rx_q_data_o  = word_q & keep_mask;
  assign flush_done_o = flush_i && rx_q_ready_i;

endmodule

`default_nettype wire

/* rtl/tx_byte_feeder.sv */
// TX queue word fetch and per-byte selection for the data phase
`default_nettype none
`timescale 1ns/100ps

module tx_byte_feeder (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  hci_pkg::cmd_info_t                       cmd_info_i,
  input  logic                                     fetch_req_i,
  output logic                                     fetch_done_o,
  input  logic [$clog2(hci_pkg::BytesPerWord)-1:0] byte_sel_i,
  output logic [7:0]                               data_byte_o,
  input  logic                                     tx_valid_i,
  input  logic [hci_pkg::QueueWidth-1:0]           tx_data_i,
  output logic                                     tx_ready_o
);

  logic [hci_pkg::QueueWidth-1:0] word_q;
  logic [hci_pkg::QueueWidth-1:0] src_word;

  // Ready only while the sequencer asks for a word
  assign tx_ready_o   = fetch_req_i;
  assign fetch_done_o = fetch_req_i && tx_valid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_q <= '0;
    end else if (fetch_done_o) begin
      word_q <= tx_data_i;
    end
  end

  // Immediate bytes come from the descriptor, byte 1 lowest
  assign src_word    = cmd_info_i.is_imm ? cmd_info_i.imm_bytes : word_q;
  assign data_byte_o = src_word[{byte_sel_i, 3'b000} +: 8];

endmodule

`default_nettype wire
